//--- dma_pkg.sv
/*
 * DMA engine shared definitions
 * bus widths, register strobe indices, control byte layout, device codes
 */
package dma_pkg;

	localparam int DATA_W  = 16;	// DRAM word
	localparam int BYTE_W  = 8;	// Z80 data bus
	localparam int NUM_STB = 9;

	// register write strobes, one bit each in port_wr
	localparam int REG_SADDR_L = 0;
	localparam int REG_SADDR_H = 1;
	localparam int REG_SADDR_X = 2;
	localparam int REG_DADDR_L = 3;
	localparam int REG_DADDR_H = 4;
	localparam int REG_DADDR_X = 5;
	localparam int REG_LEN     = 6;
	localparam int REG_CTRL    = 7;	// also launches the transfer
	localparam int REG_NUM     = 8;

	// control byte bits, device code sits in [2:0]
	localparam int CTRL_WNR    = 7;	// 0 - into RAM, 1 - from RAM
	localparam int CTRL_Z80_LP = 6;
	localparam int CTRL_SALGN  = 5;
	localparam int CTRL_DALGN  = 4;
	localparam int CTRL_ASZ    = 3;	// 256 word rows / byte blit fields

	// device codes, meaning depends on WNR
	localparam logic [2:0] DEV_RAM = 3'd1;	// WNR clear, copy
	localparam logic [2:0] DEV_BLT = 3'd1;	// WNR set, transparent blit
	localparam logic [2:0] DEV_FIL = 3'd4;	// WNR clear
	localparam logic [2:0] DEV_CRM = 3'd4;	// WNR set
	localparam logic [2:0] DEV_SFL = 3'd5;	// WNR set

endpackage

//--- dma_regs.sv
/*
 * DMA control registers
 * burst length and count, mode fields from the control byte, launch pulse
 */
`timescale 1ns/1ps

module dma_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        stb_len,
	input  logic                        stb_num,
	input  logic                        stb_ctrl,
	input  logic [dma_pkg::BYTE_W-1:0] zdata,
	output logic [2:0]                  dev,
	output logic                        wnr,
	output logic                        salgn,
	output logic                        dalgn,
	output logic                        asz,
	output logic                        z80_lp,
	output logic [dma_pkg::BYTE_W-1:0] b_len,
	output logic [dma_pkg::BYTE_W-1:0] b_num,
	output logic                        launch
);

	// mode fields and launch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dev    <= 3'd0;
			wnr    <= 1'b0;
			salgn  <= 1'b0;
			dalgn  <= 1'b0;
			asz    <= 1'b0;
			z80_lp <= 1'b0;
			launch <= 1'b0;
		end
		else
		begin
			launch <= stb_ctrl;	// lines up with the new fields
			if (stb_ctrl)
			begin
				wnr    <= zdata[dma_pkg::CTRL_WNR];
				z80_lp <= zdata[dma_pkg::CTRL_Z80_LP];
				salgn  <= zdata[dma_pkg::CTRL_SALGN];
				dalgn  <= zdata[dma_pkg::CTRL_DALGN];
				asz    <= zdata[dma_pkg::CTRL_ASZ];
				dev    <= zdata[2:0];
			end
		end
	end

	// burst geometry, both stored as count minus one
	always_ff @(posedge clk)
	begin
		if (stb_len)
			b_len <= zdata;
		if (stb_num)
			b_num <= zdata;
	end

endmodule

//--- dma_addr_gen.sv
/*
 * DMA word address generator
 * CPU-loaded start address, linear or row-aligned burst stepping
 */
`timescale 1ns/1ps

module dma_addr_gen #(
	parameter int ADDR_W = 21
) (
	input  logic                        clk,
	input  logic                        ld_l,
	input  logic                        ld_h,
	input  logic                        ld_x,
	input  logic [dma_pkg::BYTE_W-1:0] zdata,
	input  logic                        align,
	input  logic                        asz,
	input  logic                        step,
	input  logic                        burst_end,
	output logic [ADDR_W-1:0]           addr
);

	localparam int XW = ADDR_W - 13;	// bits filled by the extended register

	logic [7:0]        row;		// low byte at burst start
	logic [7:0]        low_inc;
	logic [ADDR_W-1:0] lin_next;
	logic [ADDR_W-1:0] row_base;
	logic [ADDR_W-1:0] row_adv;
	logic [ADDR_W-1:0] algn_next;

	assign lin_next = addr + ADDR_W'(1);
	assign low_inc  = addr[7:0] + 8'd1;	// no carry out in aligned mode

	// start of the current row
	assign row_base  = {addr[ADDR_W-1:8], row};
	assign row_adv   = asz ? ADDR_W'(256) : ADDR_W'(128);
	assign algn_next = burst_end ? row_base + row_adv : {addr[ADDR_W-1:8], low_inc};

	always_ff @(posedge clk)
	begin
		if (step)
		begin
			addr <= align ? algn_next : lin_next;
			if (align && burst_end)
				row <= algn_next[7:0];	// start column of the next row
		end
		else
		begin
			if (ld_l)
			begin
				addr[6:0] <= zdata[7:1];
				row[6:0]  <= zdata[7:1];
			end
			if (ld_h)
			begin
				addr[12:7] <= zdata[5:0];
				row[7]     <= zdata[0];	// same bit as addr[7]
			end
			if (ld_x)
				addr[ADDR_W-1:13] <= XW'(zdata);
		end
	end

	// CPU must not rewrite an address while the engine steps it
	a_no_load_on_step: assert property (@(posedge clk) !((ld_l || ld_h || ld_x) && step))
		else $error("address load during step");

endmodule

//--- dma_blit_merge.sv
/*
 * Blit merge, colour key 0
 * non-zero source nibbles or bytes replace the destination field
 */
`timescale 1ns/1ps

module dma_blit_merge (
	input  logic                        asz,
	input  logic [dma_pkg::DATA_W-1:0] src,
	input  logic [dma_pkg::DATA_W-1:0] dst,
	output logic [dma_pkg::DATA_W-1:0] merged
);

	localparam int NIBS  = dma_pkg::DATA_W / 4;
	localparam int BYTES = dma_pkg::DATA_W / 8;

	logic [dma_pkg::DATA_W-1:0] nib_m;
	logic [dma_pkg::DATA_W-1:0] byte_m;

	always_comb
	begin
		for (int i = 0; i < NIBS; i++)
			nib_m[i*4 +: 4] = |src[i*4 +: 4] ? src[i*4 +: 4] : dst[i*4 +: 4];
		for (int j = 0; j < BYTES; j++)
			byte_m[j*8 +: 8] = |src[j*8 +: 8] ? src[j*8 +: 8] : dst[j*8 +: 8];
	end

	assign merged = asz ? byte_m : nib_m;	// asz picks 8bpp pixels

endmodule

//--- dma_sequencer.sv
/*
 * DMA transfer sequencer
 * read/write phases, burst and word counting, data capture, device strobes
 */
`timescale 1ns/1ps

module dma_sequencer #(
	parameter int ADDR_W = 21
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        launch,
	input  logic [2:0]                  dev,
	input  logic                        wnr,
	input  logic [dma_pkg::BYTE_W-1:0] b_len,
	input  logic [dma_pkg::BYTE_W-1:0] b_num,
	input  logic [dma_pkg::DATA_W-1:0] dram_rddata,
	input  logic                        dram_next,
	input  logic [dma_pkg::DATA_W-1:0] merged,
	input  logic [ADDR_W-1:0]           src_addr,
	input  logic [ADDR_W-1:0]           dst_addr,
	output logic [ADDR_W-1:0]           dram_addr,
	output logic                        dram_req,
	output logic                        dram_rnw,
	output logic                        cram_we,
	output logic                        sfile_we,
	output logic [dma_pkg::DATA_W-1:0] data,
	output logic                        src_step,
	output logic                        dst_step,
	output logic                        burst_end,
	output logic                        dma_act
);

	logic                       act_q;
	logic                       phase;		// 0 - read, 1 - write
	logic                       phase_blt;	// 0 - source read, 1 - destination read
	logic [dma_pkg::BYTE_W-1:0] w_cnt;		// words done in this burst
	logic [dma_pkg::BYTE_W-1:0] n_cnt;		// bursts done

	logic dv_cpy, dv_blt, dv_fil, dv_crm, dv_sfl, dv_dev, dv_ok;
	logic state_dev, state_mem;
	logic mem_done, dev_done, blt_hook, phase_end, word_done, xfer_done;

	// device decode
	assign dv_cpy = !wnr && (dev == dma_pkg::DEV_RAM);
	assign dv_blt = wnr && (dev == dma_pkg::DEV_BLT);
	assign dv_fil = !wnr && (dev == dma_pkg::DEV_FIL);
	assign dv_crm = wnr && (dev == dma_pkg::DEV_CRM);
	assign dv_sfl = wnr && (dev == dma_pkg::DEV_SFL);
	assign dv_dev = dv_crm || dv_sfl;
	assign dv_ok  = dv_cpy || dv_blt || dv_fil || dv_dev;	// other codes never start

	assign dma_act = act_q || (launch && dv_ok);

	// device modes write to the device, everything else is DRAM
	assign state_dev = dv_dev && phase;
	assign state_mem = !state_dev;

	assign dram_req = dma_act && state_mem;
	assign dram_rnw = !phase;
	assign dram_addr = (!phase && !phase_blt) ? src_addr : dst_addr;

	assign cram_we  = dma_act && dv_crm && phase;
	assign sfile_we = dma_act && dv_sfl && phase;

	assign mem_done = dram_req && dram_next;
	assign dev_done = dma_act && state_dev;	// strobe completes at once
	assign blt_hook = dv_blt && !phase && !phase_blt;	// source read, dst read follows
	assign phase_end = (mem_done && !blt_hook) || dev_done;
	assign word_done = phase && phase_end;

	assign burst_end = (w_cnt == b_len);
	assign xfer_done = word_done && burst_end && (n_cnt == b_num);

	assign src_step = mem_done && !phase && !phase_blt;
	assign dst_step = word_done;

	always_ff @(posedge clk)
	begin
		if (!rst_n || xfer_done)
		begin
			act_q     <= 1'b0;	// phases and counters idle at zero
			phase     <= 1'b0;
			phase_blt <= 1'b0;
			w_cnt     <= '0;
			n_cnt     <= '0;
		end
		else
		begin
			if (launch && dv_ok)
				act_q <= 1'b1;
			if (phase_end && !(dv_fil && phase))	// fill keeps writing
				phase <= ~phase;
			if (mem_done && !phase && dv_blt)
				phase_blt <= ~phase_blt;
			if (word_done)
			begin
				if (burst_end)
				begin
					w_cnt <= '0;
					n_cnt <= n_cnt + 1'b1;
				end
				else
					w_cnt <= w_cnt + 1'b1;
			end
		end
	end

	// read data, merged over the old destination on blit dst read
	always_ff @(posedge clk)
	begin
		if (mem_done && !phase)
			data <= (dv_blt && phase_blt) ? merged : dram_rddata;
	end

	// request holds until acknowledged, transfer cannot end under it
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dram_req && !dram_next |=> dram_req && dma_act)
		else $error("dram_req dropped before dram_next");

	// device strobes exclusive and single-cycle
	a_dev_stb: assert property (@(posedge clk) disable iff (!rst_n)
		(cram_we || sfile_we) |-> !(cram_we && sfile_we) ##1 !(cram_we || sfile_we))
		else $error("bad device strobe");

endmodule

//--- dma_top.sv
/*
 * DMA engine top level
 * register file, source/destination address generators, blit merge, sequencer
 */
`timescale 1ns/1ps

module dma_top #(
	parameter int ADDR_W = 21
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [dma_pkg::NUM_STB-1:0] port_wr,
	input  logic [dma_pkg::BYTE_W-1:0]  zdata,
	input  logic [dma_pkg::DATA_W-1:0]  dram_rddata,
	input  logic                         dram_next,
	output logic [ADDR_W-1:0]            dram_addr,
	output logic [dma_pkg::DATA_W-1:0]  dram_wrdata,
	output logic                         dram_req,
	output logic                         dram_rnw,
	output logic                         cram_we,
	output logic                         sfile_we,
	output logic [7:0]                   wraddr,
	output logic [dma_pkg::DATA_W-1:0]  data,
	output logic                         dma_act,
	output logic                         dma_z80_lp
);

	logic [2:0]                  dev;
	logic                        wnr, salgn, dalgn, asz, launch;
	logic [dma_pkg::BYTE_W-1:0] b_len, b_num;
	logic [ADDR_W-1:0]           src_addr, dst_addr;
	logic                        src_step, dst_step, burst_end;
	logic [dma_pkg::DATA_W-1:0] merged;

	assign dram_wrdata = data;
	assign wraddr      = dst_addr[7:0];	// CRAM / SFILE index

	dma_regs regs_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.stb_len  (port_wr[dma_pkg::REG_LEN]),
		.stb_num  (port_wr[dma_pkg::REG_NUM]),
		.stb_ctrl (port_wr[dma_pkg::REG_CTRL]),
		.zdata    (zdata),
		.dev      (dev),
		.wnr      (wnr),
		.salgn    (salgn),
		.dalgn    (dalgn),
		.asz      (asz),
		.z80_lp   (dma_z80_lp),
		.b_len    (b_len),
		.b_num    (b_num),
		.launch   (launch)
	);

	dma_addr_gen #(.ADDR_W(ADDR_W)) src_gen_i (
		.clk       (clk),
		.ld_l      (port_wr[dma_pkg::REG_SADDR_L]),
		.ld_h      (port_wr[dma_pkg::REG_SADDR_H]),
		.ld_x      (port_wr[dma_pkg::REG_SADDR_X]),
		.zdata     (zdata),
		.align     (salgn),
		.asz       (asz),
		.step      (src_step),
		.burst_end (burst_end),
		.addr      (src_addr)
	);

	dma_addr_gen #(.ADDR_W(ADDR_W)) dst_gen_i (
		.clk       (clk),
		.ld_l      (port_wr[dma_pkg::REG_DADDR_L]),
		.ld_h      (port_wr[dma_pkg::REG_DADDR_H]),
		.ld_x      (port_wr[dma_pkg::REG_DADDR_X]),
		.zdata     (zdata),
		.align     (dalgn),
		.asz       (asz),
		.step      (dst_step),
		.burst_end (burst_end),
		.addr      (dst_addr)
	);

	dma_blit_merge merge_i (
		.asz    (asz),
		.src    (data),		// source word held from the previous read
		.dst    (dram_rddata),
		.merged (merged)
	);

	dma_sequencer #(.ADDR_W(ADDR_W)) seq_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.launch      (launch),
		.dev         (dev),
		.wnr         (wnr),
		.b_len       (b_len),
		.b_num       (b_num),
		.dram_rddata (dram_rddata),
		.dram_next   (dram_next),
		.merged      (merged),
		.src_addr    (src_addr),
		.dst_addr    (dst_addr),
		.dram_addr   (dram_addr),
		.dram_req    (dram_req),
		.dram_rnw    (dram_rnw),
		.cram_we     (cram_we),
		.sfile_we    (sfile_we),
		.data        (data),
		.src_step    (src_step),
		.dst_step    (dst_step),
		.burst_end   (burst_end),
		.dma_act     (dma_act)
	);

endmodule

//--- tb_dma.sv
/*
 * DMA engine testbench
 * DRAM model with random latency, random register programming, reference model
 */
`timescale 1ns/1ps

module tb_dma;

	localparam int ADDR_W = 21;
	localparam int TMO    = 5000;	// cycles per transfer
	localparam int M_CPY  = 0;
	localparam int M_BLT  = 1;
	localparam int M_FIL  = 2;
	localparam int M_CRM  = 3;
	localparam int M_SFL  = 4;

	logic                        clk;
	logic                        rst_n;
	logic [dma_pkg::NUM_STB-1:0] port_wr;
	logic [dma_pkg::BYTE_W-1:0]  zdata;
	logic [dma_pkg::DATA_W-1:0]  dram_rddata = '0;
	logic                        dram_next = 1'b0;
	logic [ADDR_W-1:0]           dram_addr;
	logic [dma_pkg::DATA_W-1:0]  dram_wrdata;
	logic                        dram_req, dram_rnw, cram_we, sfile_we;
	logic [7:0]                  wraddr;
	logic [dma_pkg::DATA_W-1:0]  data;
	logic                        dma_act, dma_z80_lp;

	logic [15:0] mem [int];		// DRAM contents seen by the DUT
	logic [15:0] ref_mem [int];	// reference copy
	logic [24:0] dev_got [$];	// {sfile, wraddr, data}
	logic [24:0] dev_exp [$];
	int          lat = 0;
	int          errors;
	int          checks;
	bit          hung;

	dma_top dut_i (
		.clk(clk), .rst_n(rst_n), .port_wr(port_wr), .zdata(zdata),
		.dram_rddata(dram_rddata), .dram_next(dram_next), .dram_addr(dram_addr),
		.dram_wrdata(dram_wrdata), .dram_req(dram_req), .dram_rnw(dram_rnw),
		.cram_we(cram_we), .sfile_we(sfile_we), .wraddr(wraddr), .data(data),
		.dma_act(dma_act), .dma_z80_lp(dma_z80_lp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// unwritten words, hashed from the whole address
	function automatic logic [15:0] blank_word(int a);
		logic [31:0] h;
		h = 32'(a) * 32'h9e37_79b1;
		return h[31:16];
	endfunction

	function automatic logic [15:0] dram_rd(int a);
		return mem.exists(a) ? mem[a] : blank_word(a);
	endfunction

	function automatic logic [15:0] ref_rd(int a);
		return ref_mem.exists(a) ? ref_mem[a] : blank_word(a);
	endfunction

	// DRAM model, one ack per access
	always @(posedge clk)
	begin
		#1;
		dram_next = 1'b0;
		if (rst_n && dram_req)
		begin
			if (lat == 0)
				lat = 2 + int'($urandom % 4);	// ack after 1 to 4 wait cycles
			lat = lat - 1;
			if (lat == 0)
			begin
				dram_next = 1'b1;
				if (dram_rnw)
					dram_rddata = dram_rd(int'(dram_addr));
				else
					mem[int'(dram_addr)] = dram_wrdata;
			end
		end
		else
			lat = 0;
	end

	always @(negedge clk)
	begin
		if (cram_we || sfile_we)
			dev_got.push_back({sfile_we, wraddr, data});
	end

	// address of word w in burst b of a walk that begins at start
	function automatic logic [ADDR_W-1:0] walk_addr(logic [ADDR_W-1:0] start, int len, int b,
		int w, bit align, bit asz);
		logic [ADDR_W-1:0] rs;
		logic [7:0]        col;
		if (!align)
			return start + ADDR_W'(b * (len + 1) + w);
		rs  = start + ADDR_W'(b) * (asz ? ADDR_W'(256) : ADDR_W'(128));	// row start
		col = rs[7:0] + 8'(w);	// column wraps inside the row
		return {rs[ADDR_W-1:8], col};
	endfunction

	// colour key 0 per nibble or byte
	function automatic logic [15:0] key_merge(logic [15:0] s, logic [15:0] d, bit by_byte);
		logic [15:0] r;
		r = d;
		if (by_byte)
		begin
			for (int i = 0; i < 2; i++)
				if (s[i*8 +: 8] != 8'h00)
					r[i*8 +: 8] = s[i*8 +: 8];
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				if (s[i*4 +: 4] != 4'h0)
					r[i*4 +: 4] = s[i*4 +: 4];
		end
		return r;
	endfunction

	function automatic logic [7:0] ctrl_byte(int mode, bit lp, bit salgn, bit dalgn, bit asz);
		logic [7:0] c;
		c = '0;
		case (mode)
			M_CPY:   c[2:0] = dma_pkg::DEV_RAM;
			M_BLT:   c[2:0] = dma_pkg::DEV_BLT;
			M_FIL:   c[2:0] = dma_pkg::DEV_FIL;
			M_CRM:   c[2:0] = dma_pkg::DEV_CRM;
			default: c[2:0] = dma_pkg::DEV_SFL;
		endcase
		c[dma_pkg::CTRL_WNR]    = (mode == M_BLT) || (mode == M_CRM) || (mode == M_SFL);
		c[dma_pkg::CTRL_Z80_LP] = lp;
		c[dma_pkg::CTRL_SALGN]  = salgn;
		c[dma_pkg::CTRL_DALGN]  = dalgn;
		c[dma_pkg::CTRL_ASZ]    = asz;
		return c;
	endfunction

	// reference transfer on ref_mem
	task automatic model_xfer(int mode, logic [ADDR_W-1:0] sa, logic [ADDR_W-1:0] da,
		int len, int num, bit salgn, bit dalgn, bit asz);
		logic [ADDR_W-1:0] src_a;
		logic [ADDR_W-1:0] dst_a;
		logic [15:0]       d;
		d = ref_rd(int'(sa));	// fill keeps this first word
		for (int b = 0; b <= num; b++)
			for (int w = 0; w <= len; w++)
			begin
				src_a = walk_addr(sa, len, b, w, salgn, asz);
				dst_a = walk_addr(da, len, b, w, dalgn, asz);
				if (mode != M_FIL)
					d = ref_rd(int'(src_a));
				if (mode == M_BLT)
					d = key_merge(d, ref_rd(int'(dst_a)), asz);
				if (mode == M_CRM || mode == M_SFL)
					dev_exp.push_back({mode == M_SFL, dst_a[7:0], d});
				else
					ref_mem[int'(dst_a)] = d;
			end
	endtask

	// words with many zero nibbles along an address walk
	task automatic seed_region(logic [ADDR_W-1:0] a, bit align, bit asz, int len, int num);
		logic [15:0]       v;
		logic [ADDR_W-1:0] p;
		for (int b = 0; b <= num; b++)
			for (int w = 0; w <= len; w++)
			begin
				for (int i = 0; i < 4; i++)
					v[i*4 +: 4] = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom);
				p = walk_addr(a, len, b, w, align, asz);
				mem[int'(p)] = v;
				ref_mem[int'(p)] = v;
			end
	endtask

	task automatic report_mismatch(string name, string what, logic [31:0] exp, logic [31:0] act);
		errors++;
		$display("Mismatch %s %s: expected %h actual %h", name, what, exp, act);
	endtask

	task automatic write_reg(int idx, logic [7:0] val);
		port_wr = '0;
		port_wr[idx] = 1'b1;
		zdata = val;
		@(posedge clk);
		#1;
		port_wr = '0;
	endtask

	// address, length and count strobes in random order, control last
	task automatic program_regs(logic [ADDR_W-1:0] sa, logic [ADDR_W-1:0] da,
		logic [7:0] len, logic [7:0] num, logic [7:0] ctrl);
		logic [7:0] val [dma_pkg::NUM_STB];
		int         order [$];
		int         j;
		int         t;
		val[dma_pkg::REG_SADDR_L] = {sa[6:0], 1'b0};
		val[dma_pkg::REG_SADDR_H] = {2'b00, sa[12:7]};
		val[dma_pkg::REG_SADDR_X] = sa[20:13];
		val[dma_pkg::REG_DADDR_L] = {da[6:0], 1'b0};
		val[dma_pkg::REG_DADDR_H] = {2'b00, da[12:7]};
		val[dma_pkg::REG_DADDR_X] = da[20:13];
		val[dma_pkg::REG_LEN]     = len;
		val[dma_pkg::REG_NUM]     = num;
		val[dma_pkg::REG_CTRL]    = ctrl;
		for (int k = 0; k < dma_pkg::NUM_STB; k++)
			if (k != dma_pkg::REG_CTRL)
				order.push_back(k);
		for (int k = order.size() - 1; k > 0; k--)
		begin
			j = int'($urandom % 32'(k + 1));
			t = order[k];
			order[k] = order[j];
			order[j] = t;
		end
		foreach (order[k])
			write_reg(order[k], val[order[k]]);
		write_reg(dma_pkg::REG_CTRL, val[dma_pkg::REG_CTRL]);
	endtask

	task automatic compare_mem(string name);
		foreach (mem[k])
		begin
			checks++;
			if (mem[k] !== ref_rd(k))
				report_mismatch(name, $sformatf("word %h", k), 32'(ref_rd(k)), 32'(mem[k]));
		end
		foreach (ref_mem[k])
		begin
			checks++;
			if (!mem.exists(k) && ref_mem[k] !== blank_word(k))
				report_mismatch(name, $sformatf("word %h", k), 32'(ref_mem[k]), 32'(blank_word(k)));
		end
	endtask

	task automatic run_xfer(string name, int mode, bit salgn, bit dalgn, bit asz);
		logic [ADDR_W-1:0] sa;
		logic [ADDR_W-1:0] da;
		logic [7:0]        len;
		logic [7:0]        num;
		bit                lp;
		int                n;
		sa  = ADDR_W'($urandom % 32'h000f_f000);	// source in the low half
		da  = ADDR_W'(32'h0010_0000 + $urandom % 32'h000f_f000);
		len = 8'($urandom % 8);
		num = 8'($urandom % 8);
		lp  = 1'($urandom);
		if (mode == M_BLT)
		begin
			seed_region(sa, salgn, asz, int'(len), int'(num));
			seed_region(da, dalgn, asz, int'(len), int'(num));
		end
		dev_got.delete();
		dev_exp.delete();
		model_xfer(mode, sa, da, int'(len), int'(num), salgn, dalgn, asz);
		program_regs(sa, da, len, num, ctrl_byte(mode, lp, salgn, dalgn, asz));
		checks++;
		if (!dma_act || !dram_req)
		begin
			errors++;
			$display("%s: dma_act or dram_req did not rise after the control strobe", name);
		end
		checks++;
		if (dma_z80_lp !== lp)
			report_mismatch(name, "dma_z80_lp", 32'(lp), 32'(dma_z80_lp));
		n = 0;
		while (dma_act && n < TMO)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (dma_act)
		begin
			errors++;
			hung = 1'b1;
			$display("%s: transfer still active after %0d cycles", name, TMO);
			return;
		end
		compare_mem(name);
		checks++;
		if (dev_got.size() != dev_exp.size())
			report_mismatch(name, "strobe count", 32'(dev_exp.size()), 32'(dev_got.size()));
		else
			foreach (dev_exp[i])
			begin
				checks++;
				if (dev_got[i] !== dev_exp[i])
					report_mismatch(name, $sformatf("strobe %0d", i), 32'(dev_exp[i]),
						32'(dev_got[i]));
			end
	endtask

	initial
	begin
		void'($urandom(33136));
		rst_n   = 1'b0;
		port_wr = '0;
		zdata   = '0;
		errors  = 0;
		checks  = 0;
		hung    = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		checks++;
		if (dma_act || dram_req || cram_we || sfile_we || dma_z80_lp)
		begin
			errors++;
			$display("reset: outputs not idle after reset");
		end
		for (int i = 0; i < 4 && !hung; i++)
			run_xfer("linear_copy", M_CPY, 1'b0, 1'b0, 1'($urandom));
		for (int i = 0; i < 4 && !hung; i++)
			run_xfer("aligned_copy", M_CPY, 1'($urandom), 1'b1, 1'($urandom));
		for (int i = 0; i < 4 && !hung; i++)
			run_xfer("blit", M_BLT, 1'($urandom), 1'($urandom), 1'($urandom));
		for (int i = 0; i < 3 && !hung; i++)
			run_xfer("fill", M_FIL, 1'b0, 1'($urandom), 1'($urandom));
		for (int i = 0; i < 3 && !hung; i++)
			run_xfer("cram", M_CRM, 1'($urandom), 1'($urandom), 1'($urandom));
		for (int i = 0; i < 3 && !hung; i++)
			run_xfer("sfile", M_SFL, 1'($urandom), 1'($urandom), 1'($urandom));
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- files.f
dma_pkg.sv
dma_regs.sv
dma_addr_gen.sv
dma_blit_merge.sv
dma_sequencer.sv
dma_top.sv
tb_dma.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the DMA engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_dma -Mdir obj_dir -o tb_dma
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_dma > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
